// ==== files.f ====
source/mips16_pkg.sv
source/regfile_if.sv
source/hazard_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/register_file.sv
source/hazard_unit.sv
source/mips16_core.sv
tb/core_tb.sv

// ==== source/decode_stage.sv ====
`default_nettype none

module decode_stage (
  input  wire logic                           ID_stage_inst_clk,
  input  wire logic                           ID_stage_inst_rst,
  input  mips16_pkg::instr_t                  instruction,
  input  wire logic                           stall_n,
  output logic                                branch_taken,
  output logic [mips16_pkg::IMM_W-1:0]        branch_offset,
  regfile_if.decode                           rf,
  hazard_if.decode                            hz,
  output mips16_pkg::id_ex_t                  id_ex
);
  import mips16_pkg::*;

  instr_t   ir;
  alu_cmd_e alu_cmd;
  logic     wb_en;
  logic     store_en;
  logic     load_sel;
  logic     imm_sel;
  logic     uses_src1;
  logic     uses_src2;
  word_t    imm_ext;
  id_ex_t   id_ex_next;

  always_ff @(posedge ID_stage_inst_clk or posedge ID_stage_inst_rst)
  begin
    if (ID_stage_inst_rst)
      ir <= '0;
    else if (stall_n)
      ir <= instruction;  // holds while stalled
  end

  always_comb
  begin
    wb_en     = 1'b0;
    store_en  = 1'b0;
    load_sel  = 1'b0;
    imm_sel   = 1'b0;
    uses_src1 = 1'b0;
    uses_src2 = 1'b0;
    case (ir.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SL, OP_SRA, OP_SRL:
      begin
        wb_en     = 1'b1;
        uses_src1 = 1'b1;
        uses_src2 = 1'b1;
      end
      OP_ADDI:
      begin
        wb_en     = 1'b1;
        imm_sel   = 1'b1;
        uses_src1 = 1'b1;
      end
      OP_LD:
      begin
        wb_en     = 1'b1;
        load_sel  = 1'b1;
        imm_sel   = 1'b1;
        uses_src1 = 1'b1;
      end
      OP_ST:
      begin
        store_en  = 1'b1;
        imm_sel   = 1'b1;
        uses_src1 = 1'b1;
        uses_src2 = 1'b1;  // data register in the dest field
      end
      OP_BZ:
      begin
        uses_src1 = 1'b1;
      end
      default:
      begin
        wb_en = 1'b0;  // NOP and unknown opcodes
      end
    endcase
  end

  always_comb
  begin
    case (ir.opcode)
      OP_SUB:  alu_cmd = ALU_SUB;
      OP_AND:  alu_cmd = ALU_AND;
      OP_OR:   alu_cmd = ALU_OR;
      OP_XOR:  alu_cmd = ALU_XOR;
      OP_SL:   alu_cmd = ALU_SHL;
      OP_SRA:  alu_cmd = ALU_SRA;
      OP_SRL:  alu_cmd = ALU_SRL;
      default: alu_cmd = ALU_ADD;  // also address add for LD and ST
    endcase
  end

  assign rf.rd_addr_1 = ir.src1;
  assign rf.rd_addr_2 = (ir.opcode == OP_ST) ? ir.dest : ir.lo.rr.src2;
  assign hz.src1      = uses_src1 ? rf.rd_addr_1 : '0;
  assign hz.src2      = uses_src2 ? rf.rd_addr_2 : '0;

  assign imm_ext = {{(WORD_W-IMM_W){ir.lo.imm[IMM_W-1]}}, ir.lo.imm};

  // BZ with condition 0 tests src1 for zero, other conditions never branch
  assign branch_taken  = (ir.opcode == OP_BZ) && (ir.dest == '0) && (rf.rd_data_1 == '0);
  assign branch_offset = ir.lo.imm;

  always_comb
  begin
    id_ex_next.alu_cmd    = alu_cmd;
    id_ex_next.op1        = rf.rd_data_1;
    id_ex_next.op2        = imm_sel ? imm_ext : rf.rd_data_2;
    id_ex_next.store_en   = store_en;
    id_ex_next.store_data = rf.rd_data_2;
    id_ex_next.wb_en      = wb_en;
    id_ex_next.dest       = wb_en ? ir.dest : '0;  // no dest unless it writes back
    id_ex_next.load_sel   = load_sel;
  end

  always_ff @(posedge ID_stage_inst_clk or posedge ID_stage_inst_rst)
  begin
    if (ID_stage_inst_rst)
      id_ex <= '0;
    else if (!stall_n)
      id_ex <= '0;  // bubble, same as a NOP
    else
      id_ex <= id_ex_next;
  end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`default_nettype none

module execute_stage (
  input  wire logic             ID_stage_inst_clk,
  input  wire logic             ID_stage_inst_rst,
  input  mips16_pkg::id_ex_t    id_ex,
  output mips16_pkg::ex_mem_t   ex_mem,
  hazard_if.execute             hz
);
  import mips16_pkg::*;

  word_t               alu_result;
  logic [2*WORD_W-1:0] sra_wide;

  assign sra_wide = {{WORD_W{id_ex.op1[WORD_W-1]}}, id_ex.op1} >> id_ex.op2;

  always_comb
  begin
    case (id_ex.alu_cmd)
      ALU_ADD: alu_result = id_ex.op1 + id_ex.op2;
      ALU_SUB: alu_result = id_ex.op1 - id_ex.op2;
      ALU_AND: alu_result = id_ex.op1 & id_ex.op2;
      ALU_OR:  alu_result = id_ex.op1 | id_ex.op2;
      ALU_XOR: alu_result = id_ex.op1 ^ id_ex.op2;
      ALU_SHL: alu_result = id_ex.op1 << id_ex.op2;
      ALU_SRA: alu_result = sra_wide[WORD_W-1:0];  // sign fill
      default: alu_result = id_ex.op1 >> id_ex.op2;
    endcase
  end

  always_ff @(posedge ID_stage_inst_clk or posedge ID_stage_inst_rst)
  begin
    if (ID_stage_inst_rst)
    begin
      ex_mem <= '0;
    end
    else
    begin
      ex_mem.alu_result <= alu_result;
      ex_mem.store_en   <= id_ex.store_en;
      ex_mem.store_data <= id_ex.store_data;
      ex_mem.wb_en      <= id_ex.wb_en;
      ex_mem.dest       <= id_ex.dest;
      ex_mem.load_sel   <= id_ex.load_sel;
    end
  end

  assign hz.ex_dest  = id_ex.dest;
  assign hz.mem_dest = ex_mem.dest;

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
  input  wire logic                           ID_stage_inst_clk,
  input  wire logic                           ID_stage_inst_rst,
  input  wire logic                           stall_n,
  input  wire logic                           branch_taken,
  input  wire logic [mips16_pkg::IMM_W-1:0]   branch_offset,
  output mips16_pkg::pc_t                     pc
);
  import mips16_pkg::*;

  pc_t offset_ext;

  assign offset_ext = {{(PC_W-IMM_W){branch_offset[IMM_W-1]}}, branch_offset};

  always_ff @(posedge ID_stage_inst_clk or posedge ID_stage_inst_rst)
  begin
    if (ID_stage_inst_rst)
    begin
      pc <= '0;
    end
    else if (stall_n)
    begin
      if (branch_taken)
        pc <= pc + offset_ext;  // pc already points past the branch
      else
        pc <= pc + pc_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== source/hazard_if.sv ====
`default_nettype none

interface hazard_if;
  import mips16_pkg::*;

  reg_addr_t src1;       // 0 when not read
  reg_addr_t src2;
  reg_addr_t ex_dest;    // dest of the instruction in execute
  reg_addr_t mem_dest;   // in memory
  reg_addr_t wb_dest_h;  // in write-back
  logic      stall_n;

  modport decode (output src1, src2);
  modport execute (output ex_dest, mem_dest);
  modport memory (output wb_dest_h);
  modport hazard (input src1, src2, ex_dest, mem_dest, wb_dest_h, output stall_n);

endinterface

`default_nettype wire

// ==== source/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
  hazard_if.hazard hz
);

  logic src1_hit;
  logic src2_hit;

  // a source still owed by an older instruction holds fetch and decode
  assign src1_hit = (hz.src1 != '0) &&
                    ((hz.src1 == hz.ex_dest) ||
                     (hz.src1 == hz.mem_dest) ||
                     (hz.src1 == hz.wb_dest_h));

  assign src2_hit = (hz.src2 != '0) &&
                    ((hz.src2 == hz.ex_dest) ||
                     (hz.src2 == hz.mem_dest) ||
                     (hz.src2 == hz.wb_dest_h));

  assign hz.stall_n = !(src1_hit || src2_hit);

endmodule

`default_nettype wire

// ==== source/memory_stage.sv ====
`default_nettype none

module memory_stage (
  input  wire logic             ID_stage_inst_clk,
  input  wire logic             ID_stage_inst_rst,
  input  mips16_pkg::ex_mem_t   ex_mem,
  output mips16_pkg::mem_wb_t   mem_wb,
  hazard_if.memory              hz
);
  import mips16_pkg::*;

  localparam int DMEM_ADDR_W = $clog2(DMEM_DEPTH);

  word_t                  dmem [DMEM_DEPTH];
  logic [DMEM_ADDR_W-1:0] addr;
  word_t                  load_data;

  assign addr      = ex_mem.alu_result[DMEM_ADDR_W-1:0];  // low bits only
  assign load_data = dmem[addr];

  always_ff @(posedge ID_stage_inst_clk)
  begin
    if (ex_mem.store_en)
      dmem[addr] <= ex_mem.store_data;
  end

  always_ff @(posedge ID_stage_inst_clk or posedge ID_stage_inst_rst)
  begin
    if (ID_stage_inst_rst)
    begin
      mem_wb <= '0;
    end
    else
    begin
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.load_data  <= load_data;
      mem_wb.wb_en      <= ex_mem.wb_en;
      mem_wb.dest       <= ex_mem.dest;
      mem_wb.load_sel   <= ex_mem.load_sel;
    end
  end

  assign hz.wb_dest_h = mem_wb.dest;

endmodule

`default_nettype wire

// ==== source/mips16_core.sv ====
`default_nettype none

module mips16_core (
  input  wire logic                 ID_stage_inst_clk,
  input  wire logic                 ID_stage_inst_rst,
  input  mips16_pkg::instr_t        instruction,
  output mips16_pkg::pc_t           pc,
  output logic                      wb_en,
  output mips16_pkg::reg_addr_t     wb_dest,
  output mips16_pkg::word_t         wb_data
);
  import mips16_pkg::*;

  logic             branch_taken;
  logic [IMM_W-1:0] branch_offset;
  id_ex_t           id_ex;
  ex_mem_t          ex_mem;
  mem_wb_t          mem_wb;

  regfile_if rf ();
  hazard_if  hz ();

  fetch_stage u_fetch (
    .ID_stage_inst_clk (ID_stage_inst_clk),
    .ID_stage_inst_rst (ID_stage_inst_rst),
    .stall_n           (hz.stall_n),
    .branch_taken      (branch_taken),
    .branch_offset     (branch_offset),
    .pc                (pc)
  );

  decode_stage u_decode (
    .ID_stage_inst_clk (ID_stage_inst_clk),
    .ID_stage_inst_rst (ID_stage_inst_rst),
    .instruction       (instruction),
    .stall_n           (hz.stall_n),
    .branch_taken      (branch_taken),
    .branch_offset     (branch_offset),
    .rf                (rf.decode),
    .hz                (hz.decode),
    .id_ex             (id_ex)
  );

  execute_stage u_execute (
    .ID_stage_inst_clk (ID_stage_inst_clk),
    .ID_stage_inst_rst (ID_stage_inst_rst),
    .id_ex             (id_ex),
    .ex_mem            (ex_mem),
    .hz                (hz.execute)
  );

  memory_stage u_memory (
    .ID_stage_inst_clk (ID_stage_inst_clk),
    .ID_stage_inst_rst (ID_stage_inst_rst),
    .ex_mem            (ex_mem),
    .mem_wb            (mem_wb),
    .hz                (hz.memory)
  );

  register_file u_regfile (
    .ID_stage_inst_clk (ID_stage_inst_clk),
    .ID_stage_inst_rst (ID_stage_inst_rst),
    .mem_wb            (mem_wb),
    .rf                (rf.regfile)
  );

  hazard_unit u_hazard (
    .hz (hz.hazard)
  );

  assign wb_en   = rf.wb_en;  // register file write port
  assign wb_dest = rf.wb_dest;
  assign wb_data = rf.wb_data;

endmodule

`default_nettype wire

// ==== source/mips16_pkg.sv ====
`default_nettype none

package mips16_pkg;

  localparam int WORD_W     = 16;
  localparam int PC_W       = 8;
  localparam int REG_ADDR_W = 3;
  localparam int IMM_W      = 6;
  localparam int DMEM_DEPTH = 256;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [PC_W-1:0]       pc_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // r0 reads as zero

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SL   = 4'd6,
    OP_SRA  = 4'd7,
    OP_SRL  = 4'd8,
    OP_ADDI = 4'd9,
    OP_LD   = 4'd10,
    OP_ST   = 4'd11,
    OP_BZ   = 4'd12
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SHL = 3'd5,
    ALU_SRA = 3'd6,
    ALU_SRL = 3'd7
  } alu_cmd_e;

  // low six bits are either src2 plus unused bits or the immediate
  typedef struct packed {
    reg_addr_t                    src2;
    logic [IMM_W-REG_ADDR_W-1:0]  tail;
  } instr_rr_t;

  typedef union packed {
    instr_rr_t        rr;
    logic [IMM_W-1:0] imm;
  } instr_lo_t;

  typedef struct packed {
    opcode_e   opcode;
    reg_addr_t dest;    // condition for BZ, data register for ST
    reg_addr_t src1;
    instr_lo_t lo;
  } instr_t;

  typedef struct packed {
    alu_cmd_e  alu_cmd;
    word_t     op1;
    word_t     op2;
    logic      store_en;
    word_t     store_data;
    logic      wb_en;
    reg_addr_t dest;
    logic      load_sel;
  } id_ex_t;

  typedef struct packed {
    word_t     alu_result;
    logic      store_en;
    word_t     store_data;
    logic      wb_en;
    reg_addr_t dest;
    logic      load_sel;
  } ex_mem_t;

  typedef struct packed {
    word_t     alu_result;
    word_t     load_data;
    logic      wb_en;
    reg_addr_t dest;
    logic      load_sel;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== source/regfile_if.sv ====
`default_nettype none

interface regfile_if;
  import mips16_pkg::*;

  reg_addr_t rd_addr_1;
  reg_addr_t rd_addr_2;
  word_t     rd_data_1;
  word_t     rd_data_2;
  logic      wb_en;     // write port, visible at the core outputs
  reg_addr_t wb_dest;
  word_t     wb_data;

  modport decode (output rd_addr_1, rd_addr_2, input rd_data_1, rd_data_2);
  modport regfile (input rd_addr_1, rd_addr_2,
                   output rd_data_1, rd_data_2, wb_en, wb_dest, wb_data);
  modport observer (input wb_en, wb_dest, wb_data);

endinterface

`default_nettype wire

// ==== source/register_file.sv ====
`default_nettype none

module register_file (
  input  wire logic             ID_stage_inst_clk,
  input  wire logic             ID_stage_inst_rst,
  input  mips16_pkg::mem_wb_t   mem_wb,
  regfile_if.regfile            rf
);
  import mips16_pkg::*;

  localparam int NUM_REGS = 2**REG_ADDR_W;

  word_t regs [NUM_REGS];
  word_t wb_data;

  assign wb_data = mem_wb.load_sel ? mem_wb.load_data : mem_wb.alu_result;

  always_ff @(posedge ID_stage_inst_clk or posedge ID_stage_inst_rst)
  begin
    if (ID_stage_inst_rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (mem_wb.wb_en)
    begin
      regs[mem_wb.dest] <= wb_data;  // r0 is written but never read back
    end
  end

  assign rf.rd_data_1 = (rf.rd_addr_1 == '0) ? '0 : regs[rf.rd_addr_1];
  assign rf.rd_data_2 = (rf.rd_addr_2 == '0) ? '0 : regs[rf.rd_addr_2];

  assign rf.wb_en   = mem_wb.wb_en;
  assign rf.wb_dest = mem_wb.dest;
  assign rf.wb_data = wb_data;

endmodule

`default_nettype wire

// ==== tb/core_tb.sv ====
`default_nettype none

module core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mips16_pkg::*;

  localparam int IMEM_DEPTH   = 2**PC_W;
  localparam int CLK_HALF     = 10;
  localparam int RESET_CYCLES = 16;
  localparam int WB_TIMEOUT   = 200;
  localparam int SEED         = 79;
  localparam TEST_FILE        = "tb/core_tests.txt";

  logic      ID_stage_inst_clk;
  logic      ID_stage_inst_rst;
  instr_t    instruction;
  pc_t       pc;
  logic      wb_en;
  reg_addr_t wb_dest;
  word_t     wb_data;

  word_t     imem [IMEM_DEPTH];  // instruction memory played by the testbench
  reg_addr_t exp_dest [$];
  word_t     exp_data [$];

  mips16_core dut (
    .ID_stage_inst_clk (ID_stage_inst_clk),
    .ID_stage_inst_rst (ID_stage_inst_rst),
    .instruction       (instruction),
    .pc                (pc),
    .wb_en             (wb_en),
    .wb_dest           (wb_dest),
    .wb_data           (wb_data)
  );

  initial
  begin
    ID_stage_inst_clk = 1'b0;
  end

  always #CLK_HALF ID_stage_inst_clk = ~ID_stage_inst_clk;

  // instruction fetch answered on the falling edge
  always @(negedge ID_stage_inst_clk)
  begin
    instruction = instr_t'(imem[pc]);
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_dest(input string name, input reg_addr_t actual,
                            input reg_addr_t expected);
    if (actual !== expected)
      report_failure($sformatf("CHECK FAILED at %0d ns: %s is %0d, expected %0d",
                               $time, name, actual, expected));
  endtask

  task automatic check_data(input string name, input word_t actual,
                            input word_t expected);
    if (actual !== expected)
      report_failure($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
                               $time, name, actual, expected));
  endtask

  task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
    if (actual !== expected)
      report_failure($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
                               $time, name, actual, expected));
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected)
      report_failure($sformatf("CHECK FAILED at %0d ns: %s is %b, expected %b",
                               $time, name, actual, expected));
  endtask

  // words past the program end are NOP encodings with random low bits
  task automatic fill_imem();
    logic [31:0] rnd;
    for (int i = 0; i < IMEM_DEPTH; i++)
    begin
      rnd     = $urandom;
      imem[i] = {4'h0, rnd[11:0]};
    end
  endtask

  task automatic load_tests();
    int    fd;
    int    count;
    int    field_a;
    int    field_b;
    byte   tag;
    string line;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0)
      report_failure({"cannot open the test file ", TEST_FILE});
    while ($fgets(line, fd) != 0)
    begin
      tag = line.getc(0);
      if ((tag == "P") || (tag == "E"))
      begin
        count = $sscanf(line.substr(1, line.len() - 1), "%h %h", field_a, field_b);
        if (count != 2)
          report_failure({"malformed line in the test file: ", line});
        else if (tag == "P")
        begin
          if (field_a >= IMEM_DEPTH)
            report_failure({"program address out of range: ", line});
          imem[field_a] = word_t'(field_b);
        end
        else
        begin
          exp_dest.push_back(reg_addr_t'(field_a));
          exp_data.push_back(word_t'(field_b));
        end
      end
    end
    $fclose(fd);
    if (exp_dest.size() == 0)
      report_failure("the test file holds no expected write-backs");
  endtask

  // outputs settle after the rising edge, so they are sampled on the falling one
  task automatic wait_for_writeback();
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge ID_stage_inst_clk);
      cycles++;
    end
    while ((wb_en !== 1'b1) && (cycles < WB_TIMEOUT));
    if (wb_en !== 1'b1)
      report_failure($sformatf("no write-back came within %0d cycles, stopped at %0d ns",
                               WB_TIMEOUT, $time));
  endtask

  initial
  begin
    ID_stage_inst_rst = 1'b1;
    instruction       = '0;
    void'($urandom(SEED));
    fill_imem();
    load_tests();

    repeat (RESET_CYCLES) @(negedge ID_stage_inst_clk);
    ID_stage_inst_rst = 1'b0;

    check_pc("pc", pc, '0);  // no rising edge yet since reset release
    check_flag("wb_en", wb_en, 1'b0);

    for (int i = 0; i < exp_dest.size(); i++)
    begin
      wait_for_writeback();
      check_dest($sformatf("wb_dest[%0d]", i), wb_dest, exp_dest[i]);
      check_data($sformatf("wb_data[%0d]", i), wb_data, exp_data[i]);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/core_tests.txt ====
# P lines give an instruction address and its program word in hex
# E lines give the expected write-back register and data in hex, in program order
P 00 9205  # addi r1 r0 5
P 01 943D  # addi r2 r0 -3
P 02 1650  # add  r3 r1 r2
P 03 2850  # sub  r4 r1 r2
P 04 3A50  # and  r5 r1 r2
P 05 4C50  # or   r6 r1 r2
P 06 5E50  # xor  r7 r1 r2
P 07 6688  # sl   r3 r2 r1
P 08 78C8  # sra  r4 r3 r1
P 09 8AC8  # srl  r5 r3 r1
P 0A 9C12  # addi r6 r0 0x12
P 0B BF83  # st   r7 3(r6)
P 0C A383  # ld   r1 3(r6)
P 0D 9449  # addi r2 r1 9
P 0E 1690  # add  r3 r2 r2
P 0F 68D0  # sl   r4 r3 r2
P 10 2B18  # sub  r5 r4 r3
P 11 5D68  # xor  r6 r5 r5
P 12 C183  # bz   r6 +3 taken
P 13 9E11  # addi r7 r0 0x11 delay slot
P 14 921F  # addi r1 r0 0x1f skipped
P 15 941E  # addi r2 r0 0x1e skipped
P 16 93C1  # addi r1 r7 1 branch target
P 17 C042  # bz   r1 +2 not taken
P 18 9607  # addi r3 r0 7 delay slot
P 19 980A  # addi r4 r0 0xa
P 1A 9AC1  # addi r5 r3 1
P 1B 9044  # addi r0 r1 4
P 1C 1C08  # add  r6 r0 r1
E 1 0005
E 2 FFFD
E 3 0002
E 4 0008
E 5 0005
E 6 FFFD
E 7 FFF8
E 3 FFA0
E 4 FFFD
E 5 07FD
E 6 0012
E 1 FFF8
E 2 0001
E 3 0002
E 4 0004
E 5 0002
E 6 0000
E 7 0011
E 1 0012
E 3 0007
E 4 000A
E 5 0008
E 0 0016
E 6 0012
